// ==== uart_pkg.sv ====
package uart_pkg;

    // clock cycles per serial bit
    // small divider keeps simulation short
    localparam int BAUD_DIV = 16;

    // start edge to middle of start bit
    localparam int BAUD_HALF = BAUD_DIV / 2;

    // width of the bit timer
    localparam int BAUD_W = $clog2(BAUD_DIV);

    // echo buffer size in bytes
    localparam int FIFO_DEPTH = 8;

    // one extra bit to tell full from empty
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH) + 1;

    // one character on the line
    typedef logic [7:0] byte_t;

    // data bit index, 0 to 7 plus end value
    typedef logic [3:0] bit_cnt_t;

    // cycles within one bit period
    typedef logic [BAUD_W-1:0] baud_cnt_t;

    // fifo read and write pointers
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

    // receiver frame sequencing
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    // transmitter frame sequencing
    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rxd,
    output byte_t rx_byte,
    output logic  rx_done,
    output logic  rx_busy,
    output logic  frame_err,
    output byte_t rx_count
);

    // two-flop synchronizer
    logic rxd_meta;
    logic rxd_sync;
    // one more stage for edge detection
    logic rxd_prev;
    logic start_edge;

    rx_state_t state;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_cnt;
    byte_t     shift;
    // bit timer expired, sample point
    logic      tick;

    // line idles high so the flops come out of reset high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // high to low on the synchronized line
    assign start_edge = rxd_prev & ~rxd_sync;
    assign tick       = (baud_cnt == '0);
    assign rx_busy    = (state != RX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
            rx_done   <= 1'b0;
            frame_err <= 1'b0;
            rx_count  <= '0;
        end else begin
            // pulses last one cycle
            rx_done   <= 1'b0;
            frame_err <= 1'b0;

            // bit timer counts down while a frame is in progress
            if (state != RX_IDLE) begin
                if (tick) begin
                    baud_cnt <= baud_cnt_t'(BAUD_DIV - 1);
                end else begin
                    baud_cnt <= baud_cnt - 1'b1;
                end
            end

            case (state)
                RX_IDLE: begin
                    // first sample lands mid start bit
                    if (start_edge) begin
                        state    <= RX_START;
                        baud_cnt <= baud_cnt_t'(BAUD_HALF - 1);
                    end
                end
                RX_START: begin
                    if (tick) begin
                        // line back high means a glitch, drop it
                        if (rxd_sync) begin
                            state <= RX_IDLE;
                        end else begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_cnt_t'(7)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        state <= RX_IDLE;
                        // good stop bit commits the byte
                        if (rxd_sync) begin
                            rx_done  <= 1'b1;
                            rx_count <= rx_count + 1'b1;
                        end else begin
                            frame_err <= 1'b1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb arrives first and shifts in from the top
    always_ff @(posedge clk) begin
        if (state == RX_DATA && tick) begin
            shift <= {rxd_sync, shift[7:1]};
        end
        if (state == RX_STOP && tick && rxd_sync) begin
            rx_byte <= shift;
        end
    end

    // a frame ends one way or the other
    assert property (@(posedge clk) disable iff (rst) !(rx_done && frame_err));

    // done only follows a frame in progress
    assert property (@(posedge clk) disable iff (rst) rx_done |-> $past(rx_busy));

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  cts,
    input  logic  empty,
    input  byte_t rd_data,
    output logic  pop,
    output logic  txd
);

    tx_state_t state;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_cnt;
    // byte being sent, shifts right once per data bit
    byte_t     shift;
    logic      tick;

    assign tick = (baud_cnt == '0);

    // new byte only from idle, with cts up and data waiting
    assign pop = (state == TX_IDLE) && cts && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            txd      <= 1'b1;
        end else begin
            // bit timer runs for every bit of the frame
            if (state != TX_IDLE) begin
                if (tick) begin
                    baud_cnt <= baud_cnt_t'(BAUD_DIV - 1);
                end else begin
                    baud_cnt <= baud_cnt - 1'b1;
                end
            end

            case (state)
                TX_IDLE: begin
                    // start bit begins the cycle after pop
                    if (pop) begin
                        state    <= TX_START;
                        baud_cnt <= baud_cnt_t'(BAUD_DIV - 1);
                        txd      <= 1'b0;
                    end
                end
                TX_START: begin
                    if (tick) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        txd     <= shift[0];
                    end
                end
                TX_DATA: begin
                    if (tick) begin
                        if (bit_cnt == bit_cnt_t'(7)) begin
                            // stop bit
                            state <= TX_STOP;
                            txd   <= 1'b1;
                        end else begin
                            // next bit before the shift lands
                            bit_cnt <= bit_cnt + 1'b1;
                            txd     <= shift[1];
                        end
                    end
                end
                TX_STOP: begin
                    if (tick) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // head entry is captured in the pop cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= rd_data;
        end else if (state == TX_DATA && tick) begin
            shift <= shift >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// ==== byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  byte_t wr_data,
    input  logic  pop,
    output byte_t rd_data,
    output logic  empty,
    output logic  overflow
);

    // storage for the queued bytes
    byte_t mem [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    // entries held, wraps cleanly thanks to the extra pointer bit
    fifo_ptr_t level;
    logic      full;
    logic      do_push;
    logic      do_pop;

    assign level = wr_ptr - rd_ptr;
    assign full  = (level == fifo_ptr_t'(FIFO_DEPTH));
    assign empty = (level == '0);

    // full fifo drops the incoming byte
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head of queue, always visible
    assign rd_data = mem[rd_ptr[FIFO_PTR_W-2:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_PTR_W-2:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // sticky until reset
            if (push && full) begin
                overflow <= 1'b1;
            end
        end
    end

    // pointers never drift further apart than the buffer
    assert property (@(posedge clk) disable iff (rst) level <= fifo_ptr_t'(FIFO_DEPTH));

endmodule

// ==== uart_echo_top.sv ====
`timescale 1ns/1ps

module uart_echo_top
    import uart_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  rxd,
    input  logic  cts,
    output logic  txd,
    output byte_t rx_byte,
    output logic  rx_done,
    output logic  rx_busy,
    output logic  frame_err,
    output byte_t rx_count,
    output logic  overflow
);

    // fifo head toward the transmitter
    byte_t fifo_data;
    logic  fifo_empty;
    logic  fifo_pop;

    // serial in, good bytes out with a strobe
    uart_rx u_rx (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .rx_byte   (rx_byte),
        .rx_done   (rx_done),
        .rx_busy   (rx_busy),
        .frame_err (frame_err),
        .rx_count  (rx_count)
    );

    // every rx_done pushes the byte just received
    byte_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (rx_done),
        .wr_data  (rx_byte),
        .pop      (fifo_pop),
        .rd_data  (fifo_data),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    // drains the fifo back onto the line while cts allows
    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .cts     (cts),
        .empty   (fifo_empty),
        .rd_data (fifo_data),
        .pop     (fifo_pop),
        .txd     (txd)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // reset over the first three rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== uart_echo_tb.sv ====
`timescale 1ns/1ps

module uart_echo_tb
    import uart_pkg::*;
();

    // one 8N1 character on the line
    localparam int FRAME_CYCLES = 10 * BAUD_DIV;
    localparam int WAIT_LIMIT   = 4 * FRAME_CYCLES;

    logic  clk;
    logic  rst;
    logic  rxd;
    logic  cts;
    logic  txd;
    byte_t rx_byte;
    logic  rx_done;
    logic  rx_busy;
    logic  frame_err;
    byte_t rx_count;
    logic  overflow;

    // expected bytes, receiver side and echo side
    byte_t  rx_model[$];
    byte_t  echo_model[$];
    int     done_seen  = 0;
    int     ferr_seen  = 0;
    int     echo_seen  = 0;
    int     good_count = 0;
    int     err_count  = 0;
    int     tests_ok   = 0;
    int     tests_bad  = 0;
    int     test_num   = 0;
    int     test_err_start = 0;
    integer seed = 32'h7fd2_79ed;

    // txd decoder state
    logic  tx_active = 1'b0;
    int    cap_cnt   = 0;
    int    cap_bit   = 0;
    byte_t cap_shift = '0;

    tb_clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    uart_echo_top u_uart_echo_top (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .cts       (cts),
        .txd       (txd),
        .rx_byte   (rx_byte),
        .rx_done   (rx_done),
        .rx_busy   (rx_busy),
        .frame_err (frame_err),
        .rx_count  (rx_count),
        .overflow  (overflow)
    );

    task automatic note_mismatch(string msg);
        $display("mismatch at %0d ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic note_problem(string msg);
        $display("error at %0d ns: %s", $time, msg);
        err_count++;
    endtask

    // outputs come out of reset in their idle state
    assert property (@(posedge clk) rst |=> (txd && !rx_done && !frame_err && !overflow
                                             && !rx_busy && rx_count == '0))
        else note_mismatch("outputs not at their reset values");

    // bad frame leaves the last good byte and the count alone
    assert property (@(posedge clk) disable iff (rst)
                     frame_err |-> (!rx_done && rx_count == $past(rx_count)
                                    && rx_byte == $past(rx_byte)))
        else note_mismatch("frame error disturbed rx_done, rx_byte or rx_count");

    // frame is over once the stop bit is sampled
    assert property (@(posedge clk) disable iff (rst) rx_done |-> !rx_busy)
        else note_mismatch("rx_busy still high with rx_done");

    // no new frame may start with cts low
    assert property (@(posedge clk) disable iff (rst) (!cts && !tx_active) |=> txd)
        else note_mismatch("txd left idle while cts was low");

    assert property (@(posedge clk) disable iff (rst) overflow |=> overflow)
        else note_mismatch("overflow fell without a reset");

    // receiver reports, checked against bytes in send order
    always @(negedge clk) begin
        byte_t expected;
        if (!rst && rx_done) begin
            done_seen++;
            if (rx_model.size() == 0) begin
                note_problem("rx_done pulsed with no byte outstanding");
            end else begin
                expected = rx_model.pop_front();
                assert (rx_byte == expected)
                    else note_mismatch($sformatf("rx_byte %h, expected %h", rx_byte, expected));
            end
        end
        if (!rst && frame_err) begin
            ferr_seen++;
        end
    end

    task automatic check_echo(byte_t got);
        byte_t expected;
        echo_seen++;
        if (echo_model.size() == 0) begin
            note_problem($sformatf("byte %h echoed on txd but none was expected", got));
        end else begin
            expected = echo_model.pop_front();
            assert (got == expected)
                else note_mismatch($sformatf("echoed %h, expected %h", got, expected));
        end
    endtask

    // txd decoder, samples near the middle of every bit
    always @(negedge clk) begin
        if (rst) begin
            tx_active = 1'b0;
        end else if (!tx_active) begin
            // leading edge of a start bit
            if (txd === 1'b0) begin
                tx_active = 1'b1;
                cap_cnt   = BAUD_HALF - 1;
                cap_bit   = 0;
            end
        end else if (cap_cnt > 0) begin
            cap_cnt--;
        end else begin
            cap_cnt = BAUD_DIV - 1;
            if (cap_bit == 0) begin
                if (txd !== 1'b0) begin
                    note_problem("start bit on txd did not last to its middle");
                    tx_active = 1'b0;
                end
            end else if (cap_bit <= 8) begin
                // lsb first
                cap_shift = {txd, cap_shift[7:1]};
            end else begin
                assert (txd === 1'b1) else note_mismatch("stop bit on txd was low");
                check_echo(cap_shift);
                tx_active = 1'b0;
            end
            cap_bit++;
        end
    end

    // one bit on rxd, changed on the falling edge
    task automatic drive_bit(logic value);
        @(negedge clk);
        rxd = value;
        repeat (BAUD_DIV - 1) @(negedge clk);
    endtask

    // full character, the stop value decides whether the frame is good
    task automatic send_char(byte_t data, logic stop_value, logic echoed);
        if (stop_value) begin
            rx_model.push_back(data);
            good_count++;
            if (echoed) begin
                echo_model.push_back(data);
            end
        end
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(stop_value);
        // bad stop, put the line back to idle
        if (!stop_value) begin
            drive_bit(1'b1);
        end
    endtask

    task automatic wait_for_done(int target);
        int n = 0;
        while (done_seen < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_seen < target) note_problem("timed out waiting for rx_done");
    endtask

    task automatic wait_for_ferr(int target);
        int n = 0;
        while (ferr_seen < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (ferr_seen < target) note_problem("timed out waiting for frame_err");
    endtask

    task automatic wait_for_busy(logic level);
        int n = 0;
        while (rx_busy !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rx_busy !== level) note_problem("timed out waiting on rx_busy");
    endtask

    task automatic wait_for_tx_start();
        int n = 0;
        while (!tx_active && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!tx_active) note_problem("timed out waiting for a frame on txd");
    endtask

    // every expected byte echoed and the line idle
    task automatic wait_for_drain(int limit);
        int n = 0;
        while ((echo_model.size() != 0 || tx_active) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (echo_model.size() != 0 || tx_active) note_problem("timed out waiting for echoes");
    endtask

    // a frame's worth of quiet, so a stray echo would show up
    task automatic settle();
        int n = 0;
        while (n < FRAME_CYCLES + BAUD_DIV) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic start_test(int num);
        test_num       = num;
        test_err_start = err_count;
    endtask

    task automatic finish_test(string name);
        if (err_count == test_err_start) begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", test_num, name, err_count - test_err_start);
        end
    endtask

    initial begin
        int    n;
        int    done_start;
        int    ferr_start;
        int    echo_start;
        byte_t data;
        byte_t count_before;
        byte_t byte_before;

        rxd = 1'b1;
        cts = 1'b1;

        // reset state
        start_test(1);
        n = 0;
        while (rst !== 1'b0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) note_problem("reset never released");
        @(negedge clk);
        assert (txd === 1'b1 && rx_done === 1'b0 && frame_err === 1'b0 && overflow === 1'b0
                && rx_busy === 1'b0 && rx_count === 8'd0)
            else note_mismatch("outputs not idle after reset");
        finish_test("reset state");

        // single byte, received and echoed
        start_test(2);
        data = $random(seed);
        echo_start = echo_seen;
        send_char(data, 1'b1, 1'b1);
        wait_for_done(1);
        assert (rx_byte == data) else note_mismatch("rx_byte differs from the byte sent");
        wait_for_drain(WAIT_LIMIT);
        settle();
        assert (echo_seen == echo_start + 1) else note_mismatch("wrong number of echoes");
        finish_test("single byte");

        // twenty back to back
        start_test(3);
        done_start = done_seen;
        echo_start = echo_seen;
        for (int i = 0; i < 20; i++) begin
            data = $random(seed);
            send_char(data, 1'b1, 1'b1);
        end
        wait_for_done(done_start + 20);
        wait_for_drain(WAIT_LIMIT);
        settle();
        assert (echo_seen == echo_start + 20) else note_mismatch("wrong number of echoes");
        assert (rx_count == byte_t'(good_count % 256))
            else note_mismatch($sformatf("rx_count %0d, expected %0d", rx_count, good_count));
        finish_test("streaming");

        // low stop bit
        start_test(4);
        done_start   = done_seen;
        ferr_start   = ferr_seen;
        echo_start   = echo_seen;
        count_before = rx_count;
        byte_before  = rx_byte;
        data = $random(seed);
        send_char(data, 1'b0, 1'b0);
        wait_for_ferr(ferr_start + 1);
        settle();
        assert (ferr_seen == ferr_start + 1) else note_mismatch("frame_err count wrong");
        assert (done_seen == done_start) else note_mismatch("rx_done on a bad frame");
        assert (rx_count == count_before && rx_byte == byte_before)
            else note_mismatch("rx_byte or rx_count changed on a bad frame");
        assert (echo_seen == echo_start) else note_mismatch("bad frame was echoed");
        finish_test("framing error");

        // short low pulse on rxd
        start_test(5);
        done_start = done_seen;
        ferr_start = ferr_seen;
        @(negedge clk);
        rxd = 1'b0;
        repeat (BAUD_HALF - 3) @(negedge clk);
        rxd = 1'b1;
        wait_for_busy(1'b1);
        wait_for_busy(1'b0);
        settle();
        assert (done_seen == done_start && ferr_seen == ferr_start)
            else note_mismatch("glitch was taken as a character");
        finish_test("glitch rejection");

        // cts low with one byte in flight, then nine more
        start_test(6);
        echo_start = echo_seen;
        data = $random(seed);
        send_char(data, 1'b1, 1'b1);
        wait_for_tx_start();
        @(negedge clk);
        cts = 1'b0;
        done_start = done_seen;
        for (int i = 0; i < 9; i++) begin
            data = $random(seed);
            // ninth one has no room in the fifo
            send_char(data, 1'b1, i < 8);
        end
        wait_for_done(done_start + 9);
        settle();
        assert (overflow === 1'b1) else note_mismatch("overflow low after nine bytes");
        assert (echo_seen == echo_start + 1) else note_mismatch("echo sent while cts was low");
        @(negedge clk);
        cts = 1'b1;
        wait_for_drain(12 * FRAME_CYCLES);
        settle();
        assert (echo_seen == echo_start + 9) else note_mismatch("wrong number of echoes");
        assert (overflow === 1'b1) else note_mismatch("overflow cleared after drain");
        finish_test("back-pressure and overflow");

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_ok, tests_bad, err_count);
        if (err_count == 0 && tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
uart_pkg.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
uart_echo_top.sv
tb_clock_gen.sv
uart_echo_tb.sv
